// ==== sources.f ====
src/macc_pkg.sv
src/unit_cfg_if.sv
src/mem_wr_if.sv
src/axil_cfg_regs.sv
src/run_ctrl_fsm.sv
src/addr_gen.sv
src/operand_mem.sv
src/signal_mul_add.sv
src/macc_top.sv
testbench/clk_gen.sv
testbench/tb_macc_top.sv

// ==== Makefile ====
VERILATOR  = verilator
FLAGS      = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing
TOP        = tb_macc_top
FILELIST   = sources.f
OBJ_DIR    = obj_dir
PASS_MSG   = ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# simulation output is kept in a shell variable and searched for the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/tb_macc_top.sv ====
module tb_macc_top;
   import macc_pkg::*;

   localparam int DATA_W        = 32;
   localparam int MEM_DEPTH     = 16;
   localparam int READ_LATENCY  = 1;
   localparam int ACC_W         = 2 * DATA_W;
   localparam int MAX_POLLS     = 64;
   // tests x polls x cycles per poll x period, plus margin
   localparam int WATCHDOG_TIME = 6 * MAX_POLLS * 20 * 10 + 5000;
   localparam logic [DATA_W-1:0] MAX_POS = {1'b0, {(DATA_W-1){1'b1}}};
   localparam logic [DATA_W-1:0] MIN_NEG = {1'b1, {(DATA_W-1){1'b0}}};
   localparam logic [1:0]        RESP_OKAY = 2'b00;

   logic              clk;
   logic              rst;
   logic [11:0]       awaddr;
   logic              awvalid;
   logic              awready;
   logic [DATA_W-1:0] wdata;
   logic              wvalid;
   logic              wready;
   logic [1:0]        bresp;
   logic              bvalid;
   logic              bready;
   logic [11:0]       araddr;
   logic              arvalid;
   logic              arready;
   logic [DATA_W-1:0] rdata;
   logic [1:0]        rresp;
   logic              rvalid;
   logic              rready;

   // host-side copy of the operand memories
   logic signed [DATA_W-1:0] op_a [MEM_DEPTH];
   logic signed [DATA_W-1:0] op_b [MEM_DEPTH];
   logic signed [ACC_W-1:0]  model_acc;
   integer                   seed;
   int                       errors;
   int                       tests_run;

   clk_gen #(.PERIOD(10), .RESET_CYCLES(3)) clkgen0 (.clk(clk), .rst(rst));

   macc_top #(
      .DATA_W       (DATA_W),
      .MEM_DEPTH    (MEM_DEPTH),
      .READ_LATENCY (READ_LATENCY)
   ) dut0 (
      .clk     (clk),
      .rst     (rst),
      .awaddr  (awaddr),
      .awvalid (awvalid),
      .awready (awready),
      .wdata   (wdata),
      .wvalid  (wvalid),
      .wready  (wready),
      .bresp   (bresp),
      .bvalid  (bvalid),
      .bready  (bready),
      .araddr  (araddr),
      .arvalid (arvalid),
      .arready (arready),
      .rdata   (rdata),
      .rresp   (rresp),
      .rvalid  (rvalid),
      .rready  (rready)
   );

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic check_resp(input logic [1:0] expected, input logic [1:0] actual,
                             input string what);
      if (actual !== expected) begin
         $display("ERROR at %0t: %s expected %b, got %b", $time, what, expected, actual);
         errors++;
      end
   endtask

   task automatic axil_write(input logic [11:0] addr, input logic [DATA_W-1:0] data);
      awaddr  = addr;
      wdata   = data;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      while (!awready)
         next_cycle();
      next_cycle();
      awvalid = 1'b0;
      wvalid  = 1'b0;
      bready  = 1'b1;
      while (!bvalid)
         next_cycle();
      check_resp(RESP_OKAY, bresp, "write response");
      next_cycle();
      bready = 1'b0;
   endtask

   task automatic axil_read(input logic [11:0] addr, output logic [DATA_W-1:0] data);
      araddr  = addr;
      arvalid = 1'b1;
      while (!arready)
         next_cycle();
      next_cycle();
      arvalid = 1'b0;
      rready  = 1'b1;
      while (!rvalid)
         next_cycle();
      data = rdata;
      check_resp(RESP_OKAY, rresp, "read response");
      next_cycle();
      rready = 1'b0;
   endtask

   task automatic check_result(input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual, input string what);
      if (actual !== expected) begin
         $display("ERROR at %0t: %s expected %h, got %h", $time, what, expected, actual);
         errors++;
      end
   endtask

   task automatic check_status(input logic [1:0] expected, input logic [1:0] actual,
                               input string what);
      if (actual !== expected) begin
         $display("ERROR at %0t: %s expected %b, got %b", $time, what, expected, actual);
         errors++;
      end
   endtask

   task automatic check_cfg(input cfg_word_u expected, input cfg_word_u actual,
                            input string what);
      if (actual.raw !== expected.raw) begin
         $display("ERROR at %0t: %s expected %h, got %h", $time, what, expected.raw,
                  actual.raw);
         errors++;
      end
   endtask

   // signed running sum over the host copy, addresses wrap at MEM_DEPTH
   function automatic logic signed [ACC_W-1:0] model_run(input logic signed [ACC_W-1:0] acc,
                                                         input macc_op_e op, input int amount);
      logic signed [ACC_W-1:0] sum;
      logic signed [ACC_W-1:0] prod;
      sum = acc;
      for (int i = 0; i < amount; i++) begin
         prod = ACC_W'(op_a[i % MEM_DEPTH]) * ACC_W'(op_b[i % MEM_DEPTH]);
         sum  = (op == MACC_ADD) ? sum + prod : sum - prod;
      end
      return sum;
   endfunction

   function automatic cfg_word_u make_cfg(input macc_op_e op, input logic [15:0] amount,
                                          input logic clear);
      cfg_word_u c;
      c.raw      = '0;
      c.f.op     = op;
      c.f.amount = amount;
      c.f.clear  = clear;
      return c;
   endfunction

   task automatic load_operands(input int count);
      for (int i = 0; i < count; i++) begin
         axil_write(MEM_A_BASE + 12'(4 * i), op_a[i]);
         axil_write(MEM_B_BASE + 12'(4 * i), op_b[i]);
      end
   endtask

   task automatic clear_acc();
      cfg_word_u c;
      c = make_cfg(MACC_ADD, 16'd0, 1'b1);
      axil_write(REG_CFG, c.raw);
      model_acc = '0;
   endtask

   task automatic start_run(input cfg_word_u cfg);
      cfg_word_u c;
      c         = cfg;
      c.f.start = 1'b1;
      axil_write(REG_CFG, c.raw);
   endtask

   task automatic wait_done();
      logic [DATA_W-1:0] status;
      int                polls;
      polls  = 0;
      status = '0;
      while (status[0] !== 1'b1 && polls < MAX_POLLS) begin
         axil_read(REG_STATUS, status);
         polls++;
      end
      if (status[0] !== 1'b1) begin
         $display("run did not finish within %0d status polls at %0t", MAX_POLLS, $time);
         errors++;
      end
   endtask

   task automatic run_and_wait(input cfg_word_u cfg);
      start_run(cfg);
      wait_done();
   endtask

   task automatic read_result(input string what);
      logic [DATA_W-1:0] data;
      axil_read(REG_RESULT, data);
      check_result(model_acc[DATA_W-1:0], data, what);
   endtask

   task automatic test_reset_state();
      logic [DATA_W-1:0] data;
      cfg_word_u         got;
      tests_run++;
      axil_read(REG_STATUS, data);
      check_status(2'b00, data[1:0], "status after reset");
      axil_read(REG_CFG, data);
      got.raw = data;
      check_cfg('0, got, "cfg after reset");
   endtask

   task automatic test_accumulate();
      tests_run++;
      for (int i = 0; i < 8; i++) begin
         op_a[i] = $random(seed);
         op_b[i] = $random(seed);
      end
      load_operands(8);
      clear_acc();
      run_and_wait(make_cfg(MACC_ADD, 16'd8, 1'b0));
      model_acc = model_run(model_acc, MACC_ADD, 8);
      read_result("accumulate result");
   endtask

   task automatic test_subtract();
      tests_run++;
      // second pass over entries 0 to 3, accumulator kept
      run_and_wait(make_cfg(MACC_SUB, 16'd4, 1'b0));
      model_acc = model_run(model_acc, MACC_SUB, 4);
      read_result("subtract result");
   endtask

   task automatic test_clear_readback();
      logic [DATA_W-1:0] data;
      cfg_word_u         wr_cfg;
      cfg_word_u         got;
      tests_run++;
      clear_acc();
      run_and_wait(make_cfg(MACC_ADD, 16'd0, 1'b0));
      axil_read(REG_RESULT, data);
      check_result('0, data, "result after clear");
      // the last write had start set
      axil_read(REG_CFG, data);
      got.raw = data;
      check_cfg(make_cfg(MACC_ADD, 16'd0, 1'b0), got, "cfg after start");
      wr_cfg = make_cfg(MACC_SUB, 16'd12, 1'b1);
      axil_write(REG_CFG, wr_cfg.raw);
      axil_read(REG_CFG, data);
      got.raw = data;
      check_cfg(make_cfg(MACC_SUB, 16'd12, 1'b0), got, "cfg readback");
   endtask

   task automatic test_busy();
      logic [DATA_W-1:0] data;
      tests_run++;
      clear_acc();
      start_run(make_cfg(MACC_ADD, 16'd8, 1'b0));
      axil_read(REG_STATUS, data);
      check_status(2'b10, data[1:0], "status during run");
      wait_done();
      axil_read(REG_STATUS, data);
      check_status(2'b01, data[1:0], "status after run");
      model_acc = model_run(model_acc, MACC_ADD, 8);
      read_result("busy test result");
   endtask

   task automatic test_full_depth();
      tests_run++;
      for (int i = 0; i < MEM_DEPTH; i++) begin
         op_a[i] = i[0] ? MAX_POS - DATA_W'(i) : MIN_NEG + DATA_W'(i);
         op_b[i] = i[1] ? MIN_NEG + DATA_W'(3 * i) : MAX_POS - DATA_W'(i);
      end
      load_operands(MEM_DEPTH);
      clear_acc();
      run_and_wait(make_cfg(MACC_ADD, 16'(MEM_DEPTH), 1'b0));
      model_acc = model_run(model_acc, MACC_ADD, MEM_DEPTH);
      read_result("full depth result");
   endtask

   initial begin
      seed      = 32'h5c59;
      errors    = 0;
      tests_run = 0;
      model_acc = '0;
      awaddr    = '0;
      awvalid   = 1'b0;
      wdata     = '0;
      wvalid    = 1'b0;
      bready    = 1'b0;
      araddr    = '0;
      arvalid   = 1'b0;
      rready    = 1'b0;
      wait (rst == 1'b0);
      next_cycle();

      test_reset_state();
      test_accumulate();
      test_subtract();
      test_clear_readback();
      test_busy();
      test_full_depth();

      $display("tests run: %0d, errors: %0d", tests_run, errors);
      if (errors == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin
      #(WATCHDOG_TIME);
      $display("watchdog expired after %0d time units, the tests did not complete",
               WATCHDOG_TIME);
      $display("tests run: %0d, errors: %0d", tests_run, errors + 1);
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// ==== testbench/clk_gen.sv ====
module clk_gen #(
   parameter int PERIOD       = 10,
   parameter int RESET_CYCLES = 3
) (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // released one unit after an edge, like the bus inputs
   initial begin
      rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 rst = 1'b0;
   end

endmodule

// ==== src/macc_top.sv ====
module macc_top #(
   parameter int DATA_W       = 32,
   parameter int MEM_DEPTH    = 16,
   parameter int READ_LATENCY = 1
) (
   input  logic              clk,
   input  logic              rst,

   input  logic [11:0]       awaddr,
   input  logic              awvalid,
   output logic              awready,
   input  logic [DATA_W-1:0] wdata,
   input  logic              wvalid,
   output logic              wready,
   output logic [1:0]        bresp,
   output logic              bvalid,
   input  logic              bready,
   input  logic [11:0]       araddr,
   input  logic              arvalid,
   output logic              arready,
   output logic [DATA_W-1:0] rdata,
   output logic [1:0]        rresp,
   output logic              rvalid,
   input  logic              rready
);

   unit_cfg_if ucfg ();
   mem_wr_if #(.DATA_W(DATA_W), .MEM_DEPTH(MEM_DEPTH)) mwr ();

   // read path
   logic [$clog2(MEM_DEPTH)-1:0] rd_addr;
   logic                         rd_en;
   logic [DATA_W-1:0]            rd_data_a;
   logic [DATA_W-1:0]            rd_data_b;
   logic [DATA_W-1:0]            result;

   axil_cfg_regs #(.DATA_W(DATA_W), .MEM_DEPTH(MEM_DEPTH)) regs0 (
      .clk     (clk),
      .rst     (rst),
      .awaddr  (awaddr),
      .awvalid (awvalid),
      .awready (awready),
      .wdata   (wdata),
      .wvalid  (wvalid),
      .wready  (wready),
      .bresp   (bresp),
      .bvalid  (bvalid),
      .bready  (bready),
      .araddr  (araddr),
      .arvalid (arvalid),
      .arready (arready),
      .rdata   (rdata),
      .rresp   (rresp),
      .rvalid  (rvalid),
      .rready  (rready),
      .cfg     (ucfg.regs),
      .wr      (mwr.host),
      .result  (result)
   );

   run_ctrl_fsm ctrl0 (.clk(clk), .rst(rst), .ctrl(ucfg.ctrl));

   addr_gen #(.MEM_DEPTH(MEM_DEPTH)) agen0 (
      .clk     (clk),
      .rst     (rst),
      .run     (ucfg.run),
      .amount  (ucfg.amount),
      .rd_addr (rd_addr),
      .rd_en   (rd_en)
   );

   operand_mem #(.DATA_W(DATA_W), .MEM_DEPTH(MEM_DEPTH)) mem_a (
      .clk(clk), .wr(mwr.mem), .sel_b(1'b0),
      .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data_a)
   );

   operand_mem #(.DATA_W(DATA_W), .MEM_DEPTH(MEM_DEPTH)) mem_b (
      .clk(clk), .wr(mwr.mem), .sel_b(1'b1),
      .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data_b)
   );

   signal_mul_add #(.DATA_W(DATA_W), .READ_LATENCY(READ_LATENCY)) mac0 (
      .clk    (clk),
      .rst    (rst),
      .unit   (ucfg.unit),
      .in0    (rd_data_a),
      .in1    (rd_data_b),
      .result (result)
   );

endmodule

// ==== src/signal_mul_add.sv ====
module signal_mul_add #(
   parameter int DATA_W       = 32,
   parameter int READ_LATENCY = 1
) (
   input  logic              clk,
   input  logic              rst,
   unit_cfg_if.unit          unit,
   input  logic [DATA_W-1:0] in0,
   input  logic [DATA_W-1:0] in1,
   output logic [DATA_W-1:0] result
);
   import macc_pkg::*;

   // memory read, operand register and product register
   localparam int DELAY  = READ_LATENCY + 2;
   localparam int DLY_W  = $clog2(DELAY + 1);

   logic [DLY_W-1:0]          delay;
   logic [15:0]               to_process;
   logic signed [DATA_W-1:0]  in0_q;
   logic signed [DATA_W-1:0]  in1_q;
   logic signed [2*DATA_W-1:0] product_q;
   logic signed [2*DATA_W-1:0] acc;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         unit.done  <= 1'b1;
         delay      <= '0;
         to_process <= '0;
      end else if (unit.run) begin
         unit.done  <= 1'b0;
         delay      <= DLY_W'(DELAY);
         to_process <= '0;
      end else if (delay != '0) begin
         delay <= delay - 1'b1;
         // first product arrives on the next cycle
         if (delay == DLY_W'(1)) begin
            to_process <= unit.amount;
            if (unit.amount == 16'd0)
               unit.done <= 1'b1;
         end
      end else if (!unit.done) begin
         to_process <= to_process - 16'd1;
         if (to_process == 16'd1)
            unit.done <= 1'b1;
      end
   end

   // operand and product pipeline
   always_ff @(posedge clk) begin
      in0_q     <= in0;
      in1_q     <= in1;
      product_q <= in0_q * in1_q;
      result    <= acc[DATA_W-1:0];
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         acc <= '0;
      end else if (unit.clear) begin
         acc <= '0;
      end else if (to_process != 16'd0) begin
         if (unit.op == MACC_ADD)
            acc <= acc + product_q;
         else
            acc <= acc - product_q;
      end
   end

endmodule

// ==== src/operand_mem.sv ====
module operand_mem #(
   parameter int DATA_W    = 32,
   parameter int MEM_DEPTH = 16
) (
   input  logic                         clk,
   mem_wr_if.mem                        wr,
   input  logic                         sel_b,
   input  logic                         rd_en,
   input  logic [$clog2(MEM_DEPTH)-1:0] rd_addr,
   output logic [DATA_W-1:0]            rd_data
);

   logic [DATA_W-1:0] mem [MEM_DEPTH];
   logic              we;

   // pick this instance's write enable
   assign we = sel_b ? wr.we_b : wr.we_a;

   always_ff @(posedge clk) begin
      if (we)
         mem[wr.addr] <= wr.data;
      // registered read
      if (rd_en)
         rd_data <= mem[rd_addr];
   end

endmodule

// ==== src/addr_gen.sv ====
module addr_gen #(
   parameter int MEM_DEPTH = 16
) (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         run,
   input  logic [15:0]                  amount,
   output logic [$clog2(MEM_DEPTH)-1:0] rd_addr,
   output logic                         rd_en
);

   // reads still to issue, including the current one
   logic [15:0] remaining;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         remaining <= '0;
         rd_en     <= 1'b0;
         rd_addr   <= '0;
      end else if (run) begin
         remaining <= amount;
         rd_en     <= (amount != 16'd0);
         rd_addr   <= '0;
      end else if (remaining != 16'd0) begin
         remaining <= remaining - 16'd1;
         rd_en     <= (remaining > 16'd1);
         // wraps past MEM_DEPTH
         rd_addr   <= rd_addr + 1'b1;
      end
   end

endmodule

// ==== src/run_ctrl_fsm.sv ====
module run_ctrl_fsm (
   input  logic     clk,
   input  logic     rst,
   unit_cfg_if.ctrl ctrl
);

   typedef enum logic [1:0] {
      IDLE,
      RUN,
      DRAIN
   } state_e;

   state_e state;
   logic   drain_cnt;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state        <= IDLE;
         drain_cnt    <= 1'b0;
         ctrl.run     <= 1'b0;
         ctrl.running <= 1'b0;
         ctrl.capture <= 1'b0;
      end else begin
         ctrl.run     <= 1'b0;
         ctrl.capture <= 1'b0;
         case (state)
            IDLE: begin
               if (ctrl.start) begin
                  state        <= RUN;
                  ctrl.run     <= 1'b1;
                  ctrl.running <= 1'b1;
               end
            end
            RUN: begin
               // done is still high from the last run while run is asserted
               if (!ctrl.run && ctrl.done) begin
                  state     <= DRAIN;
                  drain_cnt <= 1'b1;
               end
            end
            DRAIN: begin
               // two cycles for the result register to settle
               if (drain_cnt == 1'b0) begin
                  state        <= IDLE;
                  ctrl.capture <= 1'b1;
                  ctrl.running <= 1'b0;
               end else begin
                  drain_cnt <= 1'b0;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

endmodule

// ==== src/axil_cfg_regs.sv ====
module axil_cfg_regs #(
   parameter int DATA_W    = 32,
   parameter int MEM_DEPTH = 16
) (
   input  logic              clk,
   input  logic              rst,

   input  logic [11:0]       awaddr,
   input  logic              awvalid,
   output logic              awready,
   input  logic [DATA_W-1:0] wdata,
   input  logic              wvalid,
   output logic              wready,
   output logic [1:0]        bresp,
   output logic              bvalid,
   input  logic              bready,
   input  logic [11:0]       araddr,
   input  logic              arvalid,
   output logic              arready,
   output logic [DATA_W-1:0] rdata,
   output logic [1:0]        rresp,
   output logic              rvalid,
   input  logic              rready,

   unit_cfg_if.regs          cfg,
   mem_wr_if.host            wr,
   input  logic [DATA_W-1:0] result
);
   import macc_pkg::*;

   localparam int AW = $clog2(MEM_DEPTH);
   localparam logic [11:0] WIN_BYTES = 12'(MEM_DEPTH * 4);

   logic              wr_ready;
   logic              wr_fire;
   logic              rd_fire;
   cfg_word_u         wr_cfg;
   cfg_word_u         cfg_masked;
   cfg_word_u         cfg_reg;
   logic              status_done;
   logic [DATA_W-1:0] result_reg;
   logic [11:0]       offs_a;
   logic [11:0]       offs_b;
   logic              hit_a;
   logic              hit_b;
   logic [DATA_W-1:0] rd_word;

   // awready and wready rise together
   assign awready = wr_ready;
   assign wready  = wr_ready;
   assign bresp   = 2'b00;
   assign rresp   = 2'b00;

   assign wr_fire = wr_ready && awvalid && wvalid;
   assign rd_fire = arready && arvalid;

   // memory window decode
   assign offs_a = awaddr - MEM_A_BASE;
   assign offs_b = awaddr - MEM_B_BASE;
   assign hit_a  = (awaddr >= MEM_A_BASE) && (offs_a < WIN_BYTES);
   assign hit_b  = (awaddr >= MEM_B_BASE) && (offs_b < WIN_BYTES);

   // pulse bits never stay in the stored word
   always_comb begin
      wr_cfg.raw          = 32'(wdata);
      cfg_masked          = wr_cfg;
      cfg_masked.f.start  = 1'b0;
      cfg_masked.f.clear  = 1'b0;
   end

   assign cfg.op     = cfg_reg.f.op;
   assign cfg.amount = cfg_reg.f.amount;

   always_comb begin
      case (araddr)
         REG_CFG:    rd_word = DATA_W'(cfg_reg.raw);
         REG_STATUS: rd_word = {{(DATA_W-2){1'b0}}, cfg.running, status_done};
         REG_RESULT: rd_word = result_reg;
         // memory windows read back as zero
         default:    rd_word = '0;
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_ready    <= 1'b0;
         bvalid      <= 1'b0;
         arready     <= 1'b0;
         rvalid      <= 1'b0;
         cfg.start   <= 1'b0;
         cfg.clear   <= 1'b0;
         wr.we_a     <= 1'b0;
         wr.we_b     <= 1'b0;
         cfg_reg.raw <= '0;
         status_done <= 1'b0;
         result_reg  <= '0;
      end else begin
         cfg.start <= 1'b0;
         cfg.clear <= 1'b0;
         wr.we_a   <= 1'b0;
         wr.we_b   <= 1'b0;

         // write channel, one transaction at a time
         wr_ready <= !wr_ready && awvalid && wvalid && !bvalid;
         if (wr_fire) begin
            bvalid <= 1'b1;
            if (awaddr == REG_CFG) begin
               cfg_reg   <= cfg_masked;
               cfg.start <= wr_cfg.f.start;
               cfg.clear <= wr_cfg.f.clear;
               if (wr_cfg.f.start)
                  status_done <= 1'b0;
            end
            wr.we_a <= hit_a;
            wr.we_b <= hit_b;
         end else if (bvalid && bready) begin
            bvalid <= 1'b0;
         end

         // read channel
         arready <= !arready && arvalid && !rvalid;
         if (rd_fire)
            rvalid <= 1'b1;
         else if (rvalid && rready)
            rvalid <= 1'b0;

         if (cfg.capture) begin
            status_done <= 1'b1;
            result_reg  <= result;
         end
      end
   end

   // write payload and read data
   always_ff @(posedge clk) begin
      if (wr_fire) begin
         wr.addr <= hit_b ? offs_b[AW+1:2] : offs_a[AW+1:2];
         wr.data <= wdata;
      end
      if (rd_fire)
         rdata <= rd_word;
   end

endmodule

// ==== src/mem_wr_if.sv ====
interface mem_wr_if #(
   parameter int DATA_W    = 32,
   parameter int MEM_DEPTH = 16
);
   localparam int AW = $clog2(MEM_DEPTH);

   // one enable per operand memory, shared address and data
   logic              we_a;
   logic              we_b;
   logic [AW-1:0]     addr;
   logic [DATA_W-1:0] data;

   modport host (output we_a, we_b, addr, data);
   modport mem (input we_a, we_b, addr, data);

endinterface

// ==== src/unit_cfg_if.sv ====
interface unit_cfg_if;
   import macc_pkg::*;

   // set by the register block
   logic        start;
   logic        clear;
   macc_op_e    op;
   logic [15:0] amount;

   // run sequencing
   logic        run;
   logic        running;
   logic        capture;

   // from the arithmetic unit
   logic        done;

   modport regs (output start, clear, op, amount, input capture, running);
   modport ctrl (input start, done, output run, running, capture);
   modport unit (input run, clear, op, amount, output done);

endinterface

// ==== src/macc_pkg.sv ====
package macc_pkg;

   // register byte addresses
   localparam logic [11:0] REG_CFG    = 12'h000;
   localparam logic [11:0] REG_STATUS = 12'h004;
   localparam logic [11:0] REG_RESULT = 12'h008;

   // operand memory windows, one 32-bit word per entry
   localparam logic [11:0] MEM_A_BASE = 12'h100;
   localparam logic [11:0] MEM_B_BASE = 12'h200;

   typedef enum logic {
      MACC_ADD = 1'b0,
      MACC_SUB = 1'b1
   } macc_op_e;

   // field view of the configuration word
   typedef struct packed {
      logic [15:0] amount;
      logic [12:0] reserved;
      macc_op_e    op;
      logic        clear;
      logic        start;
   } cfg_fields_t;

   typedef union packed {
      logic [31:0] raw;
      cfg_fields_t f;
   } cfg_word_u;

endpackage
